/* hdl/sound_pkg.sv */
// sound card shared definitions

package sound_pkg;

	// audio sample and volume widths
	localparam int SAMPLE_W = 16;   // signed output sample
	localparam int VOL_W    = 4;    // one volume nibble, 0 mutes

	// mixer register indices
	localparam logic [7:0] REG_RESET   = 8'h00;
	localparam logic [7:0] REG_VOICE   = 8'h04;   // pcm channel volume
	localparam logic [7:0] REG_MASTER  = 8'h22;
	localparam logic [7:0] REG_TONE    = 8'h26;   // tone channel volume
	localparam logic [7:0] REG_IRQ_SEL = 8'h80;

	// left 12, right 12
	localparam logic [7:0] VOL_DEFAULT = 8'hCC;

	// host offsets inside the card window
	localparam logic [3:0] ADDR_INDEX  = 4'd4;
	localparam logic [3:0] ADDR_DATA   = 4'd5;
	localparam logic [3:0] ADDR_PCM    = 4'd6;
	localparam logic [3:0] ADDR_STATUS = 4'd7;   // fifo count, low water in bit 7
	localparam logic [3:0] ADDR_DIV_LO = 4'd8;
	localparam logic [3:0] ADDR_DIV_HI = 4'd9;
	localparam logic [3:0] ADDR_AMP    = 4'd10;

endpackage

/* hdl/rate_tick.sv */
// fractional rate strobe
`timescale 1ns/1ps

module rate_tick #(
	parameter int TICK_HZ = 1000000
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [27:0] clock_rate,   // system clock in Hz
	output logic        tick
);

logic [27:0] acc;
logic [28:0] sum;   // one spare bit so the add never wraps

assign sum = {1'b0, acc} + 29'(TICK_HZ);

always_ff @(posedge clk) begin
	if (!rst_n) begin
		acc  <= '0;
		tick <= 1'b0;
	end else if (sum >= {1'b0, clock_rate}) begin
		acc  <= 28'(sum - {1'b0, clock_rate});   // keep the remainder
		tick <= 1'b1;
	end else begin
		acc  <= sum[27:0];
		tick <= 1'b0;
	end
end

endmodule

/* hdl/pcm_channel.sv */
// pcm playback channel
`timescale 1ns/1ps

module pcm_channel #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic                                     push,
	input  logic [7:0]                               push_data,
	input  logic                                     tick,
	output logic signed [sound_pkg::SAMPLE_W-1:0]    sample,
	output logic [$clog2(FIFO_DEPTH + 1)-1:0]        count,
	output logic                                     low_water
);

localparam int AW = $clog2(FIFO_DEPTH);
localparam int CW = $clog2(FIFO_DEPTH + 1);
localparam logic [CW-1:0] FULL_LVL = CW'(FIFO_DEPTH);
localparam logic [CW-1:0] LOW_MARK = CW'(FIFO_DEPTH / 4);

logic [7:0]    mem [FIFO_DEPTH];
logic [AW-1:0] wr_ptr;
logic [AW-1:0] rd_ptr;
logic [7:0]    head;
logic          do_push;
logic          do_pop;

assign do_push = push && (count != FULL_LVL);   // full fifo drops the byte
assign do_pop  = tick && (count != '0);
assign head    = mem[rd_ptr];

always_ff @(posedge clk) begin
	if (do_push) begin
		mem[wr_ptr] <= push_data;
	end
end

// pointers wrap on their own, depth is a power of two
always_ff @(posedge clk) begin
	if (!rst_n) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count  <= '0;
	end else begin
		if (do_push)
			wr_ptr <= wr_ptr + 1'b1;
		if (do_pop)
			rd_ptr <= rd_ptr + 1'b1;
		case ({do_push, do_pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
		endcase
	end
end

// unsigned byte to signed sample, last value held on underrun
always_ff @(posedge clk) begin
	if (!rst_n) begin
		sample <= '0;
	end else if (do_pop) begin
		sample <= {~head[7], head[6:0], {(sound_pkg::SAMPLE_W - 8){1'b0}}};
	end
end

assign low_water = (count <= LOW_MARK);   // drives the irq

endmodule

/* hdl/tone_channel.sv */
// square wave tone channel
`timescale 1ns/1ps

module tone_channel (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  tick,
	input  logic                                  div_lo_wr,
	input  logic                                  div_hi_wr,
	input  logic                                  amp_wr,
	input  logic [7:0]                            wdata,
	output logic signed [sound_pkg::SAMPLE_W-1:0] sample
);

logic [11:0] divider;
logic [11:0] cnt;
logic [6:0]  amp;
logic        phase;   // 1 = positive half
logic signed [sound_pkg::SAMPLE_W-1:0] level;

// host writes
always_ff @(posedge clk) begin
	if (!rst_n) begin
		divider <= '0;
		amp     <= '0;
	end else begin
		if (div_lo_wr)
			divider[7:0] <= wdata;
		if (div_hi_wr)
			divider[11:8] <= wdata[3:0];   // upper bits ignored
		if (amp_wr)
			amp <= wdata[6:0];
	end
end

// phase toggles once every divider ticks
always_ff @(posedge clk) begin
	if (!rst_n) begin
		cnt   <= '0;
		phase <= 1'b1;
	end else if (divider == '0) begin
		cnt   <= '0;
		phase <= 1'b1;   // steady high level
	end else if (tick) begin
		if (cnt == '0) begin
			phase <= ~phase;
			cnt   <= divider - 1'b1;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end
end

assign level  = {{(sound_pkg::SAMPLE_W - 14){1'b0}}, amp, 7'b0};
assign sample = phase ? level : -level;

endmodule

/* hdl/mixer_regs.sv */
// mixer register file
`timescale 1ns/1ps

module mixer_regs (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             index_wr,
	input  logic                             data_wr,
	input  logic [7:0]                       wdata,
	output logic [7:0]                       rdata,
	output logic [2*sound_pkg::VOL_W-1:0]    vol_voice,
	output logic [2*sound_pkg::VOL_W-1:0]    vol_tone,
	output logic [2*sound_pkg::VOL_W-1:0]    vol_master,
	output logic [1:0]                       irq_sel
);

logic [7:0] index;
logic       restore;
logic       irq_5_en;
logic       irq_7_en;
logic       irq_10_en;

assign restore = data_wr && (index == sound_pkg::REG_RESET);

always_ff @(posedge clk) begin
	if (!rst_n)
		index <= '0;
	else if (index_wr)
		index <= wdata;
end

// volume bytes, high nibble left, low nibble right
always_ff @(posedge clk) begin
	if (!rst_n || restore) begin
		vol_voice  <= sound_pkg::VOL_DEFAULT;
		vol_tone   <= sound_pkg::VOL_DEFAULT;
		vol_master <= sound_pkg::VOL_DEFAULT;
	end else if (data_wr) begin
		case (index)
			sound_pkg::REG_VOICE:  vol_voice  <= wdata;
			sound_pkg::REG_TONE:   vol_tone   <= wdata;
			sound_pkg::REG_MASTER: vol_master <= wdata;
			default: ;
		endcase
	end
end

// irq selection survives a mixer reset write
always_ff @(posedge clk) begin
	if (!rst_n)
		irq_sel <= 2'b00;
	else if (data_wr && index == sound_pkg::REG_IRQ_SEL)
		irq_sel <= wdata[3:2];   // 01 irq 7, 10 irq 10, else irq 5
end

assign irq_7_en  = (irq_sel == 2'b01);
assign irq_10_en = (irq_sel == 2'b10);
assign irq_5_en  = !irq_7_en && !irq_10_en;

// readback of the indexed register, registered in the top level
always_comb begin
	case (index)
		sound_pkg::REG_VOICE:   rdata = vol_voice;
		sound_pkg::REG_TONE:    rdata = vol_tone;
		sound_pkg::REG_MASTER:  rdata = vol_master;
		sound_pkg::REG_IRQ_SEL: rdata = {4'h0, irq_10_en, irq_7_en, irq_5_en, 1'b0};
		default:                rdata = 8'h00;   // unknown index
	endcase
end

endmodule

/* hdl/output_mixer.sv */
// stereo volume and sum pipeline
`timescale 1ns/1ps

module output_mixer (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic signed [sound_pkg::SAMPLE_W-1:0] voice,
	input  logic signed [sound_pkg::SAMPLE_W-1:0] tone,
	input  logic [2*sound_pkg::VOL_W-1:0]         vol_voice,
	input  logic [2*sound_pkg::VOL_W-1:0]         vol_tone,
	input  logic [2*sound_pkg::VOL_W-1:0]         vol_master,
	output logic signed [sound_pkg::SAMPLE_W-1:0] sample_l,
	output logic signed [sound_pkg::SAMPLE_W-1:0] sample_r
);

localparam int SW = sound_pkg::SAMPLE_W;
localparam int VW = sound_pkg::VOL_W;

// zero mutes, otherwise shift right by 15 - v
function automatic logic signed [SW-1:0] atten(input logic signed [SW-1:0] s,
                                               input logic [VW-1:0] v);
	if (v == '0)
		return '0;
	else
		return s >>> (~v);
endfunction

logic signed [SW-1:0] voice_l, voice_r;
logic signed [SW-1:0] tone_l, tone_r;
logic signed [SW-1:0] sum_l, sum_r;

// halves of both sources, no overflow possible
assign sum_l = (voice_l >>> 1) + (tone_l >>> 1);
assign sum_r = (voice_r >>> 1) + (tone_r >>> 1);

always_ff @(posedge clk) begin
	if (!rst_n) begin
		voice_l  <= '0;
		voice_r  <= '0;
		tone_l   <= '0;
		tone_r   <= '0;
		sample_l <= '0;
		sample_r <= '0;
	end else begin
		voice_l  <= atten(voice, vol_voice[2*VW-1:VW]);   // stage 1
		voice_r  <= atten(voice, vol_voice[VW-1:0]);
		tone_l   <= atten(tone, vol_tone[2*VW-1:VW]);
		tone_r   <= atten(tone, vol_tone[VW-1:0]);
		sample_l <= atten(sum_l, vol_master[2*VW-1:VW]);   // stage 2
		sample_r <= atten(sum_r, vol_master[VW-1:0]);
	end
end

endmodule

/* hdl/sound_top.sv */
// sound card output subsystem
`timescale 1ns/1ps

module sound_top #(
	parameter int PCM_HZ     = 22050,
	parameter int TONE_HZ    = 1000000,
	parameter int FIFO_DEPTH = 16
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic [27:0]                           clock_rate,
	input  logic [3:0]                            address,
	input  logic                                  read,
	input  logic                                  write,
	input  logic [7:0]                            writedata,
	output logic [7:0]                            readdata,
	output logic signed [sound_pkg::SAMPLE_W-1:0] sample_l,
	output logic signed [sound_pkg::SAMPLE_W-1:0] sample_r,
	output logic                                  irq_5,
	output logic                                  irq_7,
	output logic                                  irq_10
);

localparam int CW = $clog2(FIFO_DEPTH + 1);

logic        pcm_tick, tone_tick;
logic [7:0]  mixer_val;
logic [7:0]  vol_voice, vol_tone, vol_master;
logic [1:0]  irq_sel;
logic [CW-1:0] count;
logic        low_water;
logic signed [sound_pkg::SAMPLE_W-1:0] voice_sample, tone_sample;

// write strobes, one per block
wire index_wr  = write && (address == sound_pkg::ADDR_INDEX);
wire data_wr   = write && (address == sound_pkg::ADDR_DATA);
wire push      = write && (address == sound_pkg::ADDR_PCM);
wire div_lo_wr = write && (address == sound_pkg::ADDR_DIV_LO);
wire div_hi_wr = write && (address == sound_pkg::ADDR_DIV_HI);
wire amp_wr    = write && (address == sound_pkg::ADDR_AMP);

always_ff @(posedge clk) begin
	if (!rst_n) begin
		readdata <= '0;
	end else if (read) begin
		case (address)
			sound_pkg::ADDR_DATA:   readdata <= mixer_val;
			sound_pkg::ADDR_STATUS: readdata <= {low_water, 7'(count)};
			default:                readdata <= 8'h00;
		endcase
	end
end

// low water irq on the selected line only
assign irq_7  = low_water && (irq_sel == 2'b01);
assign irq_10 = low_water && (irq_sel == 2'b10);
assign irq_5  = low_water && (irq_sel != 2'b01) && (irq_sel != 2'b10);

rate_tick #(.TICK_HZ(PCM_HZ)) pcm_rate (
	.clk(clk), .rst_n(rst_n), .clock_rate(clock_rate), .tick(pcm_tick)
);

rate_tick #(.TICK_HZ(TONE_HZ)) tone_rate (
	.clk(clk), .rst_n(rst_n), .clock_rate(clock_rate), .tick(tone_tick)
);

pcm_channel #(.FIFO_DEPTH(FIFO_DEPTH)) pcm (
	.clk(clk), .rst_n(rst_n), .push(push), .push_data(writedata), .tick(pcm_tick),
	.sample(voice_sample), .count(count), .low_water(low_water)
);

tone_channel tone (
	.clk(clk), .rst_n(rst_n), .tick(tone_tick), .div_lo_wr(div_lo_wr),
	.div_hi_wr(div_hi_wr), .amp_wr(amp_wr), .wdata(writedata), .sample(tone_sample)
);

mixer_regs regs (
	.clk(clk), .rst_n(rst_n), .index_wr(index_wr), .data_wr(data_wr), .wdata(writedata),
	.rdata(mixer_val), .vol_voice(vol_voice), .vol_tone(vol_tone),
	.vol_master(vol_master), .irq_sel(irq_sel)
);

output_mixer mix (
	.clk(clk), .rst_n(rst_n), .voice(voice_sample), .tone(tone_sample),
	.vol_voice(vol_voice), .vol_tone(vol_tone), .vol_master(vol_master),
	.sample_l(sample_l), .sample_r(sample_r)
);

endmodule

/* tests/sound_model.svh */
// sound card reference model
`ifndef SOUND_MODEL_SVH
`define SOUND_MODEL_SVH

logic [7:0] m_voice;
logic [7:0] m_tone;
logic [7:0] m_master;
logic [1:0] m_irq_sel;
logic [7:0] m_fifo [$];   // bytes waiting in the pcm fifo

task automatic model_init();
	m_voice   = sound_pkg::VOL_DEFAULT;
	m_tone    = sound_pkg::VOL_DEFAULT;
	m_master  = sound_pkg::VOL_DEFAULT;
	m_irq_sel = 2'b00;
	m_fifo.delete();
endtask

// the irq selection is kept across a mixer reset write
task automatic model_write(input logic [7:0] idx, input logic [7:0] data);
	case (idx)
		sound_pkg::REG_RESET: begin
			m_voice  = sound_pkg::VOL_DEFAULT;
			m_tone   = sound_pkg::VOL_DEFAULT;
			m_master = sound_pkg::VOL_DEFAULT;
		end
		sound_pkg::REG_VOICE:   m_voice   = data;
		sound_pkg::REG_TONE:    m_tone    = data;
		sound_pkg::REG_MASTER:  m_master  = data;
		sound_pkg::REG_IRQ_SEL: m_irq_sel = data[3:2];
		default: ;
	endcase
endtask

function automatic int irq_line(input logic [1:0] sel);
	case (sel)
		2'b01:   return 7;
		2'b10:   return 10;
		default: return 5;
	endcase
endfunction

function automatic logic [7:0] model_read(input logic [7:0] idx);
	case (idx)
		sound_pkg::REG_VOICE:   return m_voice;
		sound_pkg::REG_TONE:    return m_tone;
		sound_pkg::REG_MASTER:  return m_master;
		sound_pkg::REG_IRQ_SEL: return 8'(1 << (irq_line(m_irq_sel) == 5 ? 1 :
		                                        irq_line(m_irq_sel) == 7 ? 2 : 3));
		default:                return 8'h00;
	endcase
endfunction

// volume 0 mutes, v shifts right by 15 - v
function automatic logic signed [sound_pkg::SAMPLE_W-1:0] attenuate(
		input logic signed [sound_pkg::SAMPLE_W-1:0] s, input logic [3:0] v);
	if (v == 4'd0)
		return '0;
	return s >>> (15 - int'(v));
endfunction

function automatic logic signed [sound_pkg::SAMPLE_W-1:0] convert_byte(input logic [7:0] b);
	return 16'(b ^ 8'h80) << 8;   // offset binary to two's complement
endfunction

function automatic logic signed [sound_pkg::SAMPLE_W-1:0] mix_out(
		input logic signed [sound_pkg::SAMPLE_W-1:0] voice_s,
		input logic signed [sound_pkg::SAMPLE_W-1:0] tone_s, input logic left);
	logic signed [sound_pkg::SAMPLE_W-1:0] sum;
	sum = (attenuate(voice_s, left ? m_voice[7:4] : m_voice[3:0]) >>> 1) +
	      (attenuate(tone_s, left ? m_tone[7:4] : m_tone[3:0]) >>> 1);
	return attenuate(sum, left ? m_master[7:4] : m_master[3:0]);
endfunction

`endif

/* tests/sound_tb.sv */
// sound card testbench
`timescale 1ns/1ps

module sound_tb;

localparam int CLK_PERIOD   = 4;
localparam int DEPTH        = 8;
localparam int PCM_RATE     = 1000;
localparam int TONE_RATE    = 500;
localparam logic [27:0] RUN_RATE  = 28'd4000;       // pcm tick every 4 clocks
localparam logic [27:0] HOLD_RATE = 28'hFFF_FFFF;   // ticks stopped for the run
localparam int NUM_TESTS    = 5;
localparam int WORST_CYCLES = 4000;   // per test, with drain bursts
localparam int POLL_LIMIT   = 200;

logic        clk;
logic        rst_n;
logic [27:0] clock_rate;
logic [3:0]  address;
logic        read;
logic        write;
logic [7:0]  writedata;
logic [7:0]  readdata;
logic signed [sound_pkg::SAMPLE_W-1:0] sample_l;
logic signed [sound_pkg::SAMPLE_W-1:0] sample_r;
logic        irq_5;
logic        irq_7;
logic        irq_10;

integer seed;
int     errors;
int     test_errors;
int     tests_failed;

`include "sound_model.svh"

sound_top #(.PCM_HZ(PCM_RATE), .TONE_HZ(TONE_RATE), .FIFO_DEPTH(DEPTH)) UUT (
	.clk(clk), .rst_n(rst_n), .clock_rate(clock_rate), .address(address), .read(read),
	.write(write), .writedata(writedata), .readdata(readdata), .sample_l(sample_l),
	.sample_r(sample_r), .irq_5(irq_5), .irq_7(irq_7), .irq_10(irq_10)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial begin
	#(NUM_TESTS * WORST_CYCLES * CLK_PERIOD);
	$display("watchdog expired after %0d cycles, a test stopped making progress",
	         NUM_TESTS * WORST_CYCLES);
	$display("Finished with errors");
	$finish;
end

task automatic check_value(input string name, input int got, input int exp);
	assert (got == exp) else begin
		$display("error: %s = %h, expected %h", name, got, exp);
		test_errors++;
	end
endtask

task automatic bus_write(input logic [3:0] addr, input logic [7:0] data);
	@(posedge clk);
	address   <= addr;
	writedata <= data;
	write     <= 1'b1;
	@(posedge clk);
	write <= 1'b0;
endtask

task automatic bus_read(input logic [3:0] addr, output logic [7:0] data);
	@(posedge clk);
	address <= addr;
	read    <= 1'b1;
	@(posedge clk);
	read <= 1'b0;
	@(negedge clk);
	data = readdata;   // registered one cycle after read
endtask

task automatic set_rate(input logic [27:0] rate);
	@(posedge clk);
	clock_rate <= rate;
	repeat (4) @(posedge clk);   // let a tick already in flight pass
endtask

task automatic mixer_write(input logic [7:0] idx, input logic [7:0] data);
	bus_write(sound_pkg::ADDR_INDEX, idx);
	bus_write(sound_pkg::ADDR_DATA, data);
	model_write(idx, data);
endtask

task automatic mixer_check(input logic [7:0] idx);
	logic [7:0] rd;
	bus_write(sound_pkg::ADDR_INDEX, idx);
	bus_read(sound_pkg::ADDR_DATA, rd);
	check_value("readdata", int'(rd), int'(model_read(idx)));
endtask

function automatic logic [7:0] pick_index(input int n);
	case (n)
		0:       return sound_pkg::REG_RESET;
		1:       return sound_pkg::REG_VOICE;
		2:       return sound_pkg::REG_MASTER;
		3:       return sound_pkg::REG_TONE;
		4:       return sound_pkg::REG_IRQ_SEL;
		default: return 8'($random(seed));   // mostly unmapped
	endcase
endfunction

task automatic push_byte(input logic [7:0] b);
	bus_write(sound_pkg::ADDR_PCM, b);
	if (m_fifo.size() < DEPTH)
		m_fifo.push_back(b);
endtask

task automatic read_status(output int cnt, output int lw);
	logic [7:0] rd;
	bus_read(sound_pkg::ADDR_STATUS, rd);
	cnt = int'(rd[6:0]);
	lw  = int'(rd[7]);
endtask

// poll status until the fifo is empty, count may only fall
task automatic drain_fifo();
	int cnt;
	int lw;
	int last;
	int polls;
	last  = DEPTH;
	polls = 0;
	do begin
		read_status(cnt, lw);
		assert (cnt <= last) else begin
			$display("fifo count rose from %0d to %0d while draining", last, cnt);
			test_errors++;
		end
		check_value("readdata[7]", lw, int'(cnt <= DEPTH / 4));
		last = cnt;
		polls++;
	end while (cnt != 0 && polls < POLL_LIMIT);
	assert (cnt == 0) else begin
		$display("fifo did not drain within %0d status reads", POLL_LIMIT);
		test_errors++;
	end
	m_fifo.delete();
endtask

task automatic check_output(input logic signed [sound_pkg::SAMPLE_W-1:0] voice_s,
                            input logic signed [sound_pkg::SAMPLE_W-1:0] tone_s);
	repeat (4) @(posedge clk);   // two stage mixer plus margin
	@(negedge clk);
	check_value("sample_l", int'(sample_l), int'(mix_out(voice_s, tone_s, 1'b1)));
	check_value("sample_r", int'(sample_r), int'(mix_out(voice_s, tone_s, 1'b0)));
endtask

task automatic check_irq(input logic active);
	int line;
	line = irq_line(m_irq_sel);
	check_value("irq_5", int'(irq_5), int'(active && line == 5));
	check_value("irq_7", int'(irq_7), int'(active && line == 7));
	check_value("irq_10", int'(irq_10), int'(active && line == 10));
endtask

task automatic finish_test(input int num, input string name);
	$display("test %0d %s: %s, %0d errors", num, name, test_errors == 0 ? "passed" : "failed",
	         test_errors);
	if (test_errors != 0)
		tests_failed++;
	errors += test_errors;
	test_errors = 0;
endtask

task automatic test_registers();
	logic [7:0] idx;
	for (int n = 0; n < 5; n++)
		mixer_check(pick_index(n));
	for (int i = 0; i < 24; i++) begin
		idx = pick_index(int'({$random(seed)} % 32'd6));
		mixer_write(idx, 8'($random(seed)));
		mixer_check(idx);
	end
	mixer_write(sound_pkg::REG_RESET, 8'($random(seed)));
	for (int n = 0; n < 5; n++)
		mixer_check(pick_index(n));
endtask

task automatic test_fifo();
	int cnt;
	int lw;
	set_rate(HOLD_RATE);
	for (int i = 0; i < DEPTH + 3; i++) begin   // last pushes hit a full fifo
		push_byte(8'($random(seed)));
		read_status(cnt, lw);
		check_value("readdata[6:0]", cnt, m_fifo.size());
		check_value("readdata[7]", lw, int'(m_fifo.size() <= DEPTH / 4));
	end
	set_rate(RUN_RATE);
	drain_fifo();
endtask

task automatic test_tone();
	logic [7:0] data;
	mixer_write(sound_pkg::REG_VOICE, 8'h00);
	bus_write(sound_pkg::ADDR_DIV_LO, 8'h00);
	bus_write(sound_pkg::ADDR_DIV_HI, 8'h00);
	for (int i = 0; i < 8; i++) begin
		data = 8'($random(seed));
		bus_write(sound_pkg::ADDR_AMP, data);
		mixer_write(sound_pkg::REG_TONE, i == 6 ? 8'h00 : 8'($random(seed)));
		mixer_write(sound_pkg::REG_MASTER, i == 7 ? 8'h00 : 8'($random(seed)));
		check_output('0, 16'(data[6:0]) << 7);   // steady positive level
	end
endtask

task automatic test_voice();
	logic [7:0] b;
	mixer_write(sound_pkg::REG_TONE, 8'h00);
	for (int i = 0; i < 4; i++) begin
		b = 8'($random(seed));
		mixer_write(sound_pkg::REG_VOICE, 8'($random(seed)));
		mixer_write(sound_pkg::REG_MASTER, 8'($random(seed)));
		push_byte(b);
		drain_fifo();
		check_output(convert_byte(b), '0);
	end
endtask

task automatic test_irq();
	drain_fifo();
	for (int p = 0; p < 4; p++) begin
		mixer_write(sound_pkg::REG_IRQ_SEL, (8'($random(seed)) & 8'hF3) | 8'(p << 2));
		@(negedge clk);
		check_irq(1'b1);
	end
	set_rate(HOLD_RATE);
	for (int i = 0; i <= DEPTH / 4; i++)
		push_byte(8'($random(seed)));
	@(negedge clk);
	check_irq(1'b0);
	set_rate(RUN_RATE);
	drain_fifo();
	@(negedge clk);
	check_irq(1'b1);
endtask

initial begin
	seed         = 32'h2a88_76e0;
	errors       = 0;
	test_errors  = 0;
	tests_failed = 0;
	rst_n        = 1'b0;
	clock_rate   = RUN_RATE;
	address      = '0;
	read         = 1'b0;
	write        = 1'b0;
	writedata    = '0;
	model_init();
	repeat (16) @(posedge clk);
	rst_n <= 1'b1;
	test_registers();
	finish_test(1, "mixer registers");
	test_fifo();
	finish_test(2, "fifo count and low water");
	test_tone();
	finish_test(3, "tone volume");
	test_voice();
	finish_test(4, "pcm voice volume");
	test_irq();
	finish_test(5, "irq routing");
	$display("tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
	if (errors == 0)
		$display("Finished with no errors");
	else
		$display("Finished with errors");
	$finish;
end

endmodule

/* sound_mix.f */
+incdir+tests
hdl/sound_pkg.sv
hdl/rate_tick.sv
hdl/pcm_channel.sv
hdl/tone_channel.sv
hdl/mixer_regs.sv
hdl/output_mixer.sv
hdl/sound_top.sv
tests/sound_tb.sv

/* Makefile */
# all of these can be overridden on the make command line
VERILATOR ?= verilator
TOP       ?= sound_tb
FILELIST  ?= sound_mix.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
